/* Makefile */
SIM  := obj_dir/rv_fetch_sim
SRCS := $(shell grep -v '^+' build.f) logic/rv_fetch_cfg.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

$(SIM): build.f $(SRCS)
	verilator --binary --assert -j 0 -f build.f --top-module rv_fetch_tb \
		--Mdir obj_dir -o rv_fetch_sim

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+logic
logic/rv_fetch_pkg.sv
logic/rv_fetch_align.sv
logic/rv_decode_comp.sv
logic/rv_issue_stage.sv
logic/rv_fetch_expand.sv
test/rv_fetch_chk.sv
test/rv_fetch_tb.sv

/* logic/rv_decode_comp.sv */
module rv_decode_comp
    import rv_fetch_pkg::*;
(
    input  logic [31:0] i_instruction,
    output logic [31:0] o_instruction,
    output logic        o_illegal_instruction
);

    localparam logic [4:0]  REG_ZERO = 5'd0;
    localparam logic [4:0]  REG_RA   = 5'd1;
    localparam logic [4:0]  REG_SP   = 5'd2;
    localparam logic [31:0] EBREAK   = 32'h0010_0073;

    logic [15:0] c;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [11:0] imm_ci;
    logic [11:0] imm_4spn;
    logic [11:0] imm_lw;
    logic [11:0] imm_16sp;
    logic [11:0] imm_lwsp;
    logic [11:0] imm_swsp;
    logic [20:0] imm_j;
    logic [12:0] imm_b;

    function automatic logic [31:0] enc_i(
        input logic [11:0] imm,
        input logic [4:0]  rs1,
        input logic [2:0]  f3,
        input logic [4:0]  rd_i,
        input logic [4:0]  opc
    );
        return {imm, rs1, f3, rd_i, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_s(
        input logic [11:0] imm,
        input logic [4:0]  rs2_i,
        input logic [4:0]  rs1,
        input logic [2:0]  f3,
        input logic [4:0]  opc
    );
        return {imm[11:5], rs2_i, rs1, f3, imm[4:0], opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_r(
        input logic [6:0] f7,
        input logic [4:0] rs2_i,
        input logic [4:0] rs1,
        input logic [2:0] f3,
        input logic [4:0] rd_i
    );
        return {f7, rs2_i, rs1, f3, rd_i, RV32_OPC_OP, 2'b11};
    endfunction

    // register fields and immediates unscrambled once
    always_comb
    begin
        c    = i_instruction[15:0];
        rd   = c[11:7];
        rs2  = c[6:2];
        rdp  = {2'b01, c[4:2]};
        rs1p = {2'b01, c[9:7]};

        imm_ci   = {{6{c[12]}}, c[12], c[6:2]};
        imm_4spn = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
        imm_lw   = {5'b0, c[5], c[12:10], c[6], 2'b00};
        imm_16sp = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
        imm_lwsp = {4'b0, c[3:2], c[12], c[6:4], 2'b00};
        imm_swsp = {4'b0, c[8:7], c[12:9], 2'b00};
        imm_j    = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        imm_b    = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    end

    always_comb
    begin
        o_instruction         = i_instruction;
        o_illegal_instruction = 1'b0;
        case (c[1:0])
            RV32_C_Q0_DET:
            begin
                case (c[15:14])
                    2'b00:
                    begin
                        // c.addi4spn with a zero immediate is reserved
                        if (|c[12:5])
                            o_instruction = enc_i(imm_4spn, REG_SP, 3'b000, rdp, RV32_OPC_OP_IMM);
                        else
                            o_illegal_instruction = 1'b1;
                    end
                    2'b01:
                        // c.lw
                        o_instruction = enc_i(imm_lw, rs1p, 3'b010, rdp, RV32_OPC_LOAD);
                    2'b11:
                        // c.sw uses the c.lw offset layout
                        o_instruction = enc_s(imm_lw, rdp, rs1p, 3'b010, RV32_OPC_STORE);
                    default:
                        o_illegal_instruction = 1'b1;
                endcase
            end
            RV32_C_Q1_DET:
            begin
                case (c[15:13])
                    3'b000:
                        // c.addi and c.nop
                        o_instruction = enc_i(imm_ci, rd, 3'b000, rd, RV32_OPC_OP_IMM);
                    3'b001, 3'b101:
                        // c.jal links to ra and c.j to x0
                        o_instruction = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12],
                                         c[15] ? REG_ZERO : REG_RA, RV32_OPC_JAL, 2'b11};
                    3'b010:
                        // c.li
                        o_instruction = enc_i(imm_ci, REG_ZERO, 3'b000, rd, RV32_OPC_OP_IMM);
                    3'b011:
                    begin
                        if (rd == REG_SP)
                            o_instruction = enc_i(imm_16sp, REG_SP, 3'b000, REG_SP,
                                                  RV32_OPC_OP_IMM);
                        else
                            o_instruction = {{15{c[12]}}, c[6:2], rd, RV32_OPC_LUI, 2'b11};
                    end
                    3'b100:
                    begin
                        case (c[11:10])
                            2'b00, 2'b01:
                                // bit 10 picks c.srai over c.srli
                                o_instruction = enc_i({1'b0, c[10], 5'b0, c[6:2]}, rs1p, 3'b101,
                                                      rs1p, RV32_OPC_OP_IMM);
                            2'b10:
                                // c.andi
                                o_instruction = enc_i(imm_ci, rs1p, 3'b111, rs1p, RV32_OPC_OP_IMM);
                            default:
                            begin
                                case (c[6:5])
                                    2'b00:
                                        o_instruction = enc_r(7'b0100000, rdp, rs1p, 3'b000, rs1p);
                                    2'b01:
                                        o_instruction = enc_r(7'b0000000, rdp, rs1p, 3'b100, rs1p);
                                    2'b10:
                                        o_instruction = enc_r(7'b0000000, rdp, rs1p, 3'b110, rs1p);
                                    default:
                                        o_instruction = enc_r(7'b0000000, rdp, rs1p, 3'b111, rs1p);
                                endcase
                            end
                        endcase
                    end
                    default:
                        // bit 13 of c.beqz / c.bnez becomes funct3 bit 0
                        o_instruction = {imm_b[12], imm_b[10:5], REG_ZERO, rs1p, 2'b00, c[13],
                                         imm_b[4:1], imm_b[11], RV32_OPC_BRANCH, 2'b11};
                endcase
            end
            RV32_C_Q2_DET:
            begin
                case (c[15:14])
                    2'b00:
                        // c.slli
                        o_instruction = enc_i({7'b0, c[6:2]}, rd, 3'b001, rd, RV32_OPC_OP_IMM);
                    2'b01:
                        // c.lwsp
                        o_instruction = enc_i(imm_lwsp, REG_SP, 3'b010, rd, RV32_OPC_LOAD);
                    2'b10:
                    begin
                        // bit 12 and a zero rs2 split mv/jr and add/jalr/ebreak
                        if (!c[12])
                        begin
                            if (rs2 != REG_ZERO)
                                o_instruction = enc_r(7'b0, rs2, REG_ZERO, 3'b000, rd);
                            else
                                o_instruction = enc_i(12'h000, rd, 3'b000, REG_ZERO,
                                                      RV32_OPC_JALR);
                        end
                        else
                        begin
                            if (rs2 != REG_ZERO)
                                o_instruction = enc_r(7'b0, rs2, rd, 3'b000, rd);
                            else if (rd == REG_ZERO)
                                o_instruction = EBREAK;
                            else
                                o_instruction = enc_i(12'h000, rd, 3'b000, REG_RA, RV32_OPC_JALR);
                        end
                    end
                    default:
                        // c.swsp
                        o_instruction = enc_s(imm_swsp, rs2, REG_SP, 3'b010, RV32_OPC_STORE);
                endcase
            end
            default:
                // full width word with nothing to expand
                o_illegal_instruction = 1'b1;
        endcase
    end

endmodule

/* logic/rv_fetch_align.sv */
`include "rv_fetch_cfg.svh"

module rv_fetch_align
    import rv_fetch_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_fetch_valid,
    input  rv_fetch_word_u i_fetch_data,
    output logic           o_raw_valid,
    output logic [31:0]    o_raw_instr
);

    localparam int DEPTH = `RV_ALIGN_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [15:0]      hw_mem [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] head_nxt;
    logic [PTR_W-1:0] head_p1;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] tail_p1;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_nxt;
    logic [15:0]      head_hw;
    logic [15:0]      next_hw;
    logic             head_is_32;
    logic [1:0]       pop_len;

    // circular pointer add for a depth that need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_add(
        input logic [PTR_W-1:0] ptr,
        input int unsigned      inc
    );
        int unsigned sum;
        sum = ptr + inc;
        if (sum >= DEPTH)
        begin
            sum = sum - DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    always_comb
    begin
        head_p1 = ptr_add(head_q, 1);
        tail    = ptr_add(head_q, 32'(count_q));
        tail_p1 = ptr_add(tail, 1);

        head_hw = hw_mem[head_q];
        next_hw = hw_mem[head_p1];

        // quadrant 3 at the head means two halfwords are needed
        head_is_32 = (head_hw[1:0] == 2'b11);
        pop_len    = head_is_32 ? 2'd2 : 2'd1;
    end

    always_comb
    begin
        if (head_is_32)
        begin
            o_raw_valid = (count_q >= CNT_W'(2));
            o_raw_instr = {next_hw, head_hw};
        end
        else
        begin
            o_raw_valid = (count_q != '0);
            o_raw_instr = {16'h0000, head_hw};
        end
    end

    // pop before push so the count never wraps in between
    always_comb
    begin
        head_nxt  = head_q;
        count_nxt = count_q;
        if (o_raw_valid)
        begin
            head_nxt  = ptr_add(head_q, 32'(pop_len));
            count_nxt = count_nxt - CNT_W'(pop_len);
        end
        if (i_fetch_valid)
        begin
            count_nxt = count_nxt + CNT_W'(2);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            head_q  <= '0;
            count_q <= '0;
        end
        else
        begin
            head_q  <= head_nxt;
            count_q <= count_nxt;
        end
    end

    // both halves land behind the last buffered halfword
    always_ff @(posedge i_clk)
    begin
        if (i_fetch_valid)
        begin
            hw_mem[tail]    <= i_fetch_data.half[0];
            hw_mem[tail_p1] <= i_fetch_data.half[1];
        end
    end

endmodule

/* logic/rv_fetch_cfg.svh */
`ifndef RV_FETCH_CFG_SVH
`define RV_FETCH_CFG_SVH

// pc of the first instruction after reset
`define RV_RESET_PC 32'h0000_0000

// aligner capacity in halfwords
// even values of 4 and up keep a whole fetch word plus a pending half
`define RV_ALIGN_DEPTH 4

`endif

/* logic/rv_fetch_expand.sv */
module rv_fetch_expand
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_fetch_valid,
    input  logic [31:0] i_fetch_data,
    output logic        o_valid,
    output logic [31:0] o_instr,
    output logic [31:0] o_pc,
    output logic        o_compressed,
    output logic        o_illegal
);

    logic        raw_valid;
    logic [31:0] raw_instr;
    logic [31:0] exp_instr;
    logic        exp_illegal;

    rv_fetch_align u_align
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_data  (i_fetch_data),
        .o_raw_valid   (raw_valid),
        .o_raw_instr   (raw_instr)
    );

    // expansion runs on every head word and the issue stage picks the result
    rv_decode_comp u_decode
    (
        .i_instruction         (raw_instr),
        .o_instruction         (exp_instr),
        .o_illegal_instruction (exp_illegal)
    );

    rv_issue_stage u_issue
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_raw_valid   (raw_valid),
        .i_raw_instr   (raw_instr),
        .i_exp_instr   (exp_instr),
        .i_exp_illegal (exp_illegal),
        .o_valid       (o_valid),
        .o_instr       (o_instr),
        .o_pc          (o_pc),
        .o_compressed  (o_compressed),
        .o_illegal     (o_illegal)
    );

endmodule

/* logic/rv_fetch_pkg.sv */
package rv_fetch_pkg;

    // major opcodes, instruction bits 6:2
    localparam logic [4:0] RV32_OPC_LOAD   = 5'b00000;
    localparam logic [4:0] RV32_OPC_STORE  = 5'b01000;
    localparam logic [4:0] RV32_OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] RV32_OPC_OP     = 5'b01100;
    localparam logic [4:0] RV32_OPC_LUI    = 5'b01101;
    localparam logic [4:0] RV32_OPC_BRANCH = 5'b11000;
    localparam logic [4:0] RV32_OPC_JAL    = 5'b11011;
    localparam logic [4:0] RV32_OPC_JALR   = 5'b11001;

    // compressed quadrants, bits 1:0
    // 2'b11 marks a full 32-bit instruction
    localparam logic [1:0] RV32_C_Q0_DET = 2'b00;
    localparam logic [1:0] RV32_C_Q1_DET = 2'b01;
    localparam logic [1:0] RV32_C_Q2_DET = 2'b10;

    // fetch word seen whole or as two halfwords
    // half[0] is the lower address
    typedef union packed
    {
        logic [31:0]      word;
        logic [1:0][15:0] half;
    } rv_fetch_word_u;

endpackage

/* logic/rv_issue_stage.sv */
`include "rv_fetch_cfg.svh"

module rv_issue_stage
    import rv_fetch_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_raw_valid,
    input  logic [31:0] i_raw_instr,
    input  logic [31:0] i_exp_instr,
    input  logic        i_exp_illegal,
    output logic        o_valid,
    output logic [31:0] o_instr,
    output logic [31:0] o_pc,
    output logic        o_compressed,
    output logic        o_illegal
);

    logic [31:0] pc_q;
    logic        is_comp;
    logic [31:0] sel_instr;

    always_comb
    begin
        is_comp = i_raw_instr[1:0] inside {RV32_C_Q0_DET, RV32_C_Q1_DET, RV32_C_Q2_DET};
        if (!is_comp)
            sel_instr = i_raw_instr;
        else if (i_exp_illegal)
            sel_instr = {16'h0000, i_raw_instr[15:0]};
        else
            sel_instr = i_exp_instr;
    end

    // pc of the next instruction to leave
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
            pc_q    <= `RV_RESET_PC;
        end
        else
        begin
            o_valid <= i_raw_valid;
            if (i_raw_valid)
                pc_q <= pc_q + (is_comp ? 32'd2 : 32'd4);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_raw_valid)
        begin
            o_instr      <= sel_instr;
            o_pc         <= pc_q;
            o_compressed <= is_comp;
            o_illegal    <= is_comp & i_exp_illegal;
        end
    end

endmodule

/* test/rv_fetch_chk.sv */
`include "rv_fetch_cfg.svh"

module rv_fetch_chk
(
    input logic                                   i_clk,
    input logic                                   i_rst_n,
    input logic                                   i_fetch_valid,
    input logic [$clog2(`RV_ALIGN_DEPTH + 1)-1:0] i_count,
    input logic                                   i_raw_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // halfword fill never passes the buffer capacity
    count_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        int'(i_count) <= `RV_ALIGN_DEPTH)
        else $error("aligner holds %0d halfwords, above its depth", i_count);

    // the source leaves an idle cycle after every strobe
    strobe_spacing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fetch_valid |=> !i_fetch_valid)
        else $error("fetch strobe high in two consecutive cycles");

    reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !i_raw_valid)
        else $error("raw_valid high while reset is asserted");

endmodule

/* test/rv_fetch_tb.sv */
`include "rv_fetch_cfg.svh"

module rv_fetch_tb
    import rv_fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic [31:0] fetch_data;
    logic        o_valid;
    logic [31:0] o_instr;
    logic [31:0] o_pc;
    logic        o_compressed;
    logic        o_illegal;

    logic [15:0] half_q[$];
    logic [31:0] exp_instr_q[$];
    logic [31:0] exp_pc_q[$];
    bit          exp_comp_q[$];
    bit          exp_ill_q[$];
    logic [31:0] gen_pc;
    bit          fed = 1'b0;
    int          errors = 0;
    int          checked = 0;
    int          total = 0;

    rv_fetch_expand DUT
    (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_fetch_valid (fetch_valid),
        .i_fetch_data  (fetch_data),
        .o_valid       (o_valid),
        .o_instr       (o_instr),
        .o_pc          (o_pc),
        .o_compressed  (o_compressed),
        .o_illegal     (o_illegal)
    );

    bind rv_fetch_align rv_fetch_chk u_chk
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_fetch_valid (i_fetch_valid),
        .i_count       (count_q),
        .i_raw_valid   (o_raw_valid)
    );

    always #5 clk = ~clk;

    // rv32i base formats
    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], RV32_OPC_STORE, 2'b11};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, RV32_OPC_OP, 2'b11};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] o, input logic [4:0] rs1,
                                          input logic [2:0] f3);
        return {o[12], o[10:5], 5'd0, rs1, f3, o[4:1], o[11], RV32_OPC_BRANCH, 2'b11};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] o, input logic [4:0] rd);
        return {o[20], o[10:1], o[11], o[19:12], rd, RV32_OPC_JAL, 2'b11};
    endfunction

    // builds one instruction of the given class and queues its expected result
    task automatic make_instr(input int kind);
        logic [31:0] rnd;
        logic [31:0] im;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [2:0]  pd;
        logic [2:0]  ps;
        logic [4:0]  xd;
        logic [4:0]  xs;
        logic [5:0]  i6;
        logic [11:0] se6;
        logic [9:0]  u10;
        logic [6:0]  u7;
        logic [7:0]  u8;
        logic [9:0]  s10;
        logic [11:0] o12;
        logic [8:0]  o9;
        logic [2:0]  f3;
        logic [15:0] c;
        logic [31:0] enc;
        logic [31:0] want;
        bit          wide;
        bit          ill;
        rnd  = $urandom;
        im   = $urandom;
        rd   = (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0];
        rs2  = (rnd[9:5] == 5'd0) ? 5'd1 : rnd[9:5];
        pd   = rnd[12:10];
        ps   = rnd[15:13];
        xd   = {2'b01, pd};
        xs   = {2'b01, ps};
        i6   = rnd[21:16];
        se6  = {{6{i6[5]}}, i6};
        u10  = {(im[7:0] == 8'h00) ? 8'h01 : im[7:0], 2'b00};
        u7   = {im[4:0], 2'b00};
        u8   = {im[5:0], 2'b00};
        s10  = {i6, 4'b0000};
        o12  = {im[10:0], 1'b0};
        o9   = {im[7:0], 1'b0};
        c    = 16'h0000;
        enc  = 32'h0;
        wide = 1'b0;
        ill  = 1'b0;
        case (kind)
            0:
            begin
                c    = {3'b000, u10[5:4], u10[9:6], u10[2], u10[3], pd, RV32_C_Q0_DET};
                want = itype({2'b00, u10}, 5'd2, 3'b000, xd, RV32_OPC_OP_IMM);
            end
            1:
            begin
                c    = {3'b010, u7[5:3], ps, u7[2], u7[6], pd, RV32_C_Q0_DET};
                want = itype({5'b0, u7}, xs, 3'b010, xd, RV32_OPC_LOAD);
            end
            2:
            begin
                c    = {3'b110, u7[5:3], ps, u7[2], u7[6], pd, RV32_C_Q0_DET};
                want = stype({5'b0, u7}, xd, xs, 3'b010);
            end
            3:
            begin
                // rd of zero is c.nop
                c    = {3'b000, i6[5], rnd[4:0], i6[4:0], RV32_C_Q1_DET};
                want = itype(se6, rnd[4:0], 3'b000, rnd[4:0], RV32_OPC_OP_IMM);
            end
            4, 5:
            begin
                c    = {(kind == 4) ? 3'b001 : 3'b101, o12[11], o12[4], o12[9:8], o12[10],
                        o12[6], o12[7], o12[3:1], o12[5], RV32_C_Q1_DET};
                want = jtype({{9{o12[11]}}, o12}, (kind == 4) ? 5'd1 : 5'd0);
            end
            6:
            begin
                c    = {3'b010, i6[5], rd, i6[4:0], RV32_C_Q1_DET};
                want = itype(se6, 5'd0, 3'b000, rd, RV32_OPC_OP_IMM);
            end
            7:
            begin
                if (rd == 5'd2)
                    rd = 5'd3;
                c    = {3'b011, i6[5], rd, i6[4:0], RV32_C_Q1_DET};
                want = {{14{i6[5]}}, i6, rd, RV32_OPC_LUI, 2'b11};
            end
            8:
            begin
                // c.addi16sp shares funct3 with c.lui and has sp as rd
                c    = {3'b011, s10[9], 5'd2, s10[4], s10[6], s10[8:7], s10[5], RV32_C_Q1_DET};
                want = itype({{2{s10[9]}}, s10}, 5'd2, 3'b000, 5'd2, RV32_OPC_OP_IMM);
            end
            9:
            begin
                c    = {3'b100, 1'b0, 2'b00, ps, i6[4:0], RV32_C_Q1_DET};
                want = itype({7'b0000000, i6[4:0]}, xs, 3'b101, xs, RV32_OPC_OP_IMM);
            end
            10:
            begin
                c    = {3'b100, 1'b0, 2'b01, ps, i6[4:0], RV32_C_Q1_DET};
                want = itype({7'b0100000, i6[4:0]}, xs, 3'b101, xs, RV32_OPC_OP_IMM);
            end
            11:
            begin
                c    = {3'b100, i6[5], 2'b10, ps, i6[4:0], RV32_C_Q1_DET};
                want = itype(se6, xs, 3'b111, xs, RV32_OPC_OP_IMM);
            end
            12, 13, 14, 15:
            begin
                // sub, xor, or, and
                f3   = (kind == 12) ? 3'b000 : (kind == 13) ? 3'b100 :
                       (kind == 14) ? 3'b110 : 3'b111;
                c    = {6'b100011, ps, kind[1:0], pd, RV32_C_Q1_DET};
                want = rtype((kind == 12) ? 7'b0100000 : 7'b0000000, xd, xs, f3, xs);
            end
            16, 17:
            begin
                c    = {(kind == 16) ? 3'b110 : 3'b111, o9[8], o9[4:3], ps, o9[7:6], o9[2:1],
                        o9[5], RV32_C_Q1_DET};
                want = btype({{4{o9[8]}}, o9}, xs, (kind == 16) ? 3'b000 : 3'b001);
            end
            18:
            begin
                c    = {3'b000, 1'b0, rd, i6[4:0], RV32_C_Q2_DET};
                want = itype({7'b0, i6[4:0]}, rd, 3'b001, rd, RV32_OPC_OP_IMM);
            end
            19:
            begin
                c    = {3'b010, u8[5], rd, u8[4:2], u8[7:6], RV32_C_Q2_DET};
                want = itype({4'b0, u8}, 5'd2, 3'b010, rd, RV32_OPC_LOAD);
            end
            20:
            begin
                c    = {4'b1000, rd, rs2, RV32_C_Q2_DET};
                want = rtype(7'b0, rs2, 5'd0, 3'b000, rd);
            end
            21:
            begin
                c    = {4'b1000, rd, 5'd0, RV32_C_Q2_DET};
                want = itype(12'h000, rd, 3'b000, 5'd0, RV32_OPC_JALR);
            end
            22:
            begin
                c    = {4'b1001, rd, rs2, RV32_C_Q2_DET};
                want = rtype(7'b0, rs2, rd, 3'b000, rd);
            end
            23:
            begin
                c    = 16'h9002;
                want = 32'h0010_0073;
            end
            24:
            begin
                c    = {4'b1001, rd, 5'd0, RV32_C_Q2_DET};
                want = itype(12'h000, rd, 3'b000, 5'd1, RV32_OPC_JALR);
            end
            25:
            begin
                c    = {3'b110, u8[5:2], u8[7:6], rs2, RV32_C_Q2_DET};
                want = stype({4'b0, u8}, rs2, 5'd2, 3'b010);
            end
            26:
            begin
                // quadrant 0 with bits 15:14 = 10 is reserved
                c    = {2'b10, im[11:0], RV32_C_Q0_DET};
                want = {16'h0000, c};
                ill  = 1'b1;
            end
            27:
            begin
                c    = {3'b000, 8'h00, pd, RV32_C_Q0_DET};
                want = {16'h0000, c};
                ill  = 1'b1;
            end
            default:
            begin
                wide = 1'b1;
                enc  = {im[31:2], 2'b11};
                want = enc;
            end
        endcase
        if (!wide)
            enc = {16'h0000, c};
        half_q.push_back(enc[15:0]);
        if (wide)
            half_q.push_back(enc[31:16]);
        exp_instr_q.push_back(want);
        exp_pc_q.push_back(gen_pc);
        exp_comp_q.push_back(!wide);
        exp_ill_q.push_back(ill);
        gen_pc = gen_pc + (wide ? 32'd4 : 32'd2);
    endtask

    // outputs are registered on the rising edge, so compare in the low phase
    always @(negedge clk)
    begin
        if (o_valid === 1'b1)
        begin
            if (!fed)
            begin
                $display("Error at %0t: o_valid high before any fetch word", $time);
                errors++;
            end
            if (exp_instr_q.size() == 0)
            begin
                $display("Error at %0t: unexpected instruction %h at pc %h", $time, o_instr, o_pc);
                errors++;
            end
            else
            begin
                checked++;
                if (o_instr !== exp_instr_q[0])
                begin
                    $display("Error at %0t: pc %h instr expected %h, got %h", $time,
                             exp_pc_q[0], exp_instr_q[0], o_instr);
                    errors++;
                end
                if (o_pc !== exp_pc_q[0])
                begin
                    $display("Error at %0t: pc expected %h, got %h", $time, exp_pc_q[0], o_pc);
                    errors++;
                end
                if (o_compressed !== exp_comp_q[0] || o_illegal !== exp_ill_q[0])
                begin
                    $display("Error at %0t: pc %h flags expected c=%0b i=%0b, got c=%0b i=%0b",
                             $time, exp_pc_q[0], exp_comp_q[0], exp_ill_q[0], o_compressed,
                             o_illegal);
                    errors++;
                end
                void'(exp_instr_q.pop_front());
                void'(exp_pc_q.pop_front());
                void'(exp_comp_q.pop_front());
                void'(exp_ill_q.pop_front());
            end
        end
    end

    initial
    begin
        rv_fetch_word_u w;
        int             n;
        int             idle;
        int             wait_cycles;
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_data  = 32'h0;
        void'($urandom(32'h4bc50d82));
        gen_pc = `RV_RESET_PC;

        // every class once, then a random mix, padded to whole fetch words
        for (n = 0; n < 28; n++)
            make_instr(n);
        while (n < 300 || (half_q.size() % 2) != 0)
        begin
            make_instr($urandom_range(0, 39));
            n++;
        end
        total = exp_instr_q.size();

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (half_q.size() != 0)
        begin
            @(negedge clk);
            w.half[0]   = half_q.pop_front();
            w.half[1]   = half_q.pop_front();
            fetch_data  = w.word;
            fetch_valid = 1'b1;
            fed        <= 1'b1;
            @(negedge clk);
            fetch_valid = 1'b0;
            idle        = $urandom_range(1, 3);
            repeat (idle - 1) @(negedge clk);
        end

        wait_cycles = 0;
        while (exp_instr_q.size() != 0 && wait_cycles < 200)
        begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_instr_q.size() != 0)
        begin
            $display("Timeout: %0d instructions never left the DUT", exp_instr_q.size());
            errors++;
        end
        repeat (5) @(posedge clk);

        $display("instructions %0d, checked %0d, errors %0d", total, checked, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
